//--- common/cmd_in_macros.svh
// Sizing and header layout shared by the command-input dispatcher.
// The valid flag must stay in the top bit of the header word; the byte
// that gets cleared on retire is derived from ENTRY_VALID_BIT.
`ifndef CMD_IN_MACROS_SVH
`define CMD_IN_MACROS_SVH

// accelerator count and id width
`define MAX_ACCS 16
`define ACC_BITS 4

// 64 words per subqueue, memory address is {acc_id, index}
`define SUBQUEUE_BITS 6
`define QUEUE_ADDR_BITS (`ACC_BITS + `SUBQUEUE_BITS)

// header word field positions
`define ENTRY_VALID_BIT 63
`define CMD_CODE_LSB 32
`define CMD_CODE_BITS 4
`define NUM_ARGS_LSB 8
`define NUM_ARGS_BITS 4

`endif

//--- common/cmd_format_pkg.sv
// Command word format as seen by the dispatcher.
// Only the valid flag, the command code and the argument count are
// interpreted; everything else in the header is carried untouched.
`default_nettype none

`include "cmd_in_macros.svh"

package cmd_format_pkg;

    // codes found in header bits CMD_CODE_LSB and up
    typedef enum logic [`CMD_CODE_BITS-1:0] {
        EXEC_TASK     = 4'h1,
        SETUP_INST    = 4'h2,
        EXEC_PERIODIC = 4'h5
    } cmd_code_e;

    // header word split into its fields, msb first
    typedef struct packed {
        logic                                                    valid;
        logic [`ENTRY_VALID_BIT-`CMD_CODE_LSB-`CMD_CODE_BITS-1:0] payload_hi;
        cmd_code_e                                               code;
        logic [`CMD_CODE_LSB-`NUM_ARGS_LSB-`NUM_ARGS_BITS-1:0]   payload_mid;
        logic [`NUM_ARGS_BITS-1:0]                               num_args;
        logic [`NUM_ARGS_LSB-1:0]                                payload_lo;
    } cmd_header_t;

endpackage

`default_nettype wire

//--- common/dispatch_pkg.sv
// Datapath types of the dispatcher: FSM states, memory port requests,
// the selection handed to the dispatch stage and the output stream beat.
`default_nettype none

`include "cmd_in_macros.svh"

package dispatch_pkg;

    typedef enum logic [2:0] {
        IDLE,
        READ_HEADER,
        CHECK_HEADER,
        SEND,
        RETIRE,
        CHECK_NEXT
    } dispatch_state_e;

    // one memory port access, write when any byte enable is set
    typedef struct packed {
        logic                        en;
        logic [7:0]                  be;
        logic [`QUEUE_ADDR_BITS-1:0] addr;
        logic [63:0]                 wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`ACC_BITS-1:0] acc_id;
        logic                 from_internal;
    } dispatch_req_t;

    typedef struct packed {
        logic [63:0]          data;
        logic [`ACC_BITS-1:0] dest;
        logic                 last;
    } stream_beat_t;

endpackage

`default_nettype wire

//--- hw/cmd_queue_ram.sv
// True dual-port command memory, 64-bit words with byte enables.
// Read data is registered and only changes on an enabled access, so it
// holds while a port is idle. Reads during a write return the old word.
// Simultaneous writes to one address from both ports: port B wins.
`timescale 1ns/1ns
`default_nettype none

`include "cmd_in_macros.svh"

module cmd_queue_ram import dispatch_pkg::*; (
    input  wire logic     clk,
    input  wire mem_req_t a_req,
    output logic [63:0]   a_rdata,
    input  wire mem_req_t b_req,
    output logic [63:0]   b_rdata
);

    logic [63:0] mem [2**`QUEUE_ADDR_BITS];

    always_ff @(posedge clk) begin
        if (a_req.en) begin
            a_rdata <= mem[a_req.addr];
            for (int i = 0; i < 8; i++) begin
                if (a_req.be[i]) begin
                    mem[a_req.addr][8*i +: 8] <= a_req.wdata[8*i +: 8];
                end
            end
        end
        // port b last so it takes a same-address collision
        if (b_req.en) begin
            b_rdata <= mem[b_req.addr];
            for (int i = 0; i < 8; i++) begin
                if (b_req.be[i]) begin
                    mem[b_req.addr][8*i +: 8] <= b_req.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/acc_select.sv
// Selection stage. Picks the next accelerator to serve while the
// dispatch stage is idle; internal commands take priority, lowest id
// first, then host subqueues are polled round-robin. A host pick does
// not know whether the subqueue holds a command, the dispatch stage
// finds out from the header. Set strobes win over retire clears.
`timescale 1ns/1ns
`default_nettype none

`include "cmd_in_macros.svh"

module acc_select import dispatch_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire logic                 nempty_wr,
    input  wire logic [`ACC_BITS-1:0] nempty_addr,
    input  wire logic                 avail_wr,
    input  wire logic [`ACC_BITS-1:0] avail_addr,
    input  wire logic                 dispatch_idle,
    input  wire logic                 retire,
    input  wire logic                 retire_busy,
    input  wire logic                 retire_empty,
    input  wire logic                 retire_skip,
    output logic                      sel_valid,
    output dispatch_req_t             sel
);

    logic [`MAX_ACCS-1:0] avail_q;
    logic [`MAX_ACCS-1:0] nempty_q;
    logic [`ACC_BITS-1:0] rr_ptr;
    logic [`ACC_BITS-1:0] rr_next;
    logic                 try_now;
    logic                 pick_valid;
    dispatch_req_t        pick;

    // one attempt per idle period, sel_valid blocks a second one
    assign try_now = dispatch_idle && !sel_valid;

    assign rr_next = (rr_ptr == `ACC_BITS'(`MAX_ACCS - 1)) ? '0 : rr_ptr + 1'b1;

    always_comb begin
        // host candidate by default
        pick       = '{acc_id: rr_ptr, from_internal: 1'b0};
        pick_valid = avail_q[rr_ptr];
        // descending scan leaves the lowest qualifying id
        for (int i = `MAX_ACCS - 1; i >= 0; i--) begin
            if (nempty_q[i] && avail_q[i]) begin
                pick.acc_id        = `ACC_BITS'(i);
                pick.from_internal = 1'b1;
                pick_valid         = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            avail_q   <= '1;
            nempty_q  <= '0;
            rr_ptr    <= '0;
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= try_now && pick_valid;
            // pointer moves on every host attempt, served or not
            if (try_now && !pick.from_internal) begin
                rr_ptr <= rr_next;
            end
            // sel still names the retiring accelerator here
            if (retire && !retire_skip) begin
                if (retire_busy) begin
                    avail_q[sel.acc_id] <= 1'b0;
                end
                if (retire_empty) begin
                    nempty_q[sel.acc_id] <= 1'b0;
                end
            end
            if (nempty_wr) begin
                nempty_q[nempty_addr] <= 1'b1;
            end
            if (avail_wr) begin
                avail_q[avail_addr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (try_now && pick_valid) begin
            sel <= pick;
        end
    end

endmodule

`default_nettype wire

//--- cmd_dispatch/cmd_dispatch.sv
// Dispatch stage. Takes one selection at a time, reads the header at the
// stored subqueue index, streams the whole command and retires it.
// Only host headers are checked for validity; an internal pick implies
// a pending command. Only the header's valid byte is cleared on retire,
// argument words are left in place. Indices wrap inside the subqueue.
`timescale 1ns/1ns
`default_nettype none

`include "cmd_in_macros.svh"

module cmd_dispatch import dispatch_pkg::*, cmd_format_pkg::*; (
    input  wire logic          clk,
    input  wire logic          rstn,
    input  wire logic          sel_valid,
    input  wire dispatch_req_t sel,
    output logic               dispatch_idle,
    output mem_req_t           host_b_req,
    output mem_req_t           int_b_req,
    input  wire logic [63:0]   host_b_rdata,
    input  wire logic [63:0]   int_b_rdata,
    output logic               out_valid,
    output stream_beat_t       out_beat,
    input  wire logic          out_ready,
    output logic               retire,
    output logic               retire_busy,
    output logic               retire_empty,
    output logic               retire_skip
);

    // byte lane holding the entry valid flag
    localparam logic [7:0] VALID_BYTE_BE = 8'h1 << (`ENTRY_VALID_BIT / 8);

    dispatch_state_e state;

    // per-accelerator read position in each queue
    logic [`SUBQUEUE_BITS-1:0] host_idx [`MAX_ACCS];
    logic [`SUBQUEUE_BITS-1:0] int_idx  [`MAX_ACCS];

    logic [`ACC_BITS-1:0]      acc_id;
    logic                      from_internal;
    logic [`SUBQUEUE_BITS-1:0] sel_idx;
    logic [`SUBQUEUE_BITS-1:0] first_idx;
    logic [`SUBQUEUE_BITS-1:0] cur_idx;
    logic [`SUBQUEUE_BITS-1:0] next_idx;
    logic [5:0]                beats_left;
    cmd_code_e                 code_q;
    logic                      skip_q;
    logic                      next_valid;
    logic [63:0]               rdata;
    cmd_header_t               hdr;
    mem_req_t                  port_req;
    logic                      beat_done;

    // words in a command, header included
    function automatic logic [5:0] cmd_length(input cmd_header_t h);
        logic [5:0] arg_words;
        arg_words = {1'b0, h.num_args, 1'b0};
        case (h.code)
            SETUP_INST: return 6'd2;
            EXEC_TASK:  return 6'd3 + arg_words;
            default:    return 6'd4 + arg_words;
        endcase
    endfunction

    assign rdata     = from_internal ? int_b_rdata : host_b_rdata;
    assign hdr       = cmd_header_t'(rdata);
    assign sel_idx   = sel.from_internal ? int_idx[sel.acc_id] : host_idx[sel.acc_id];
    assign next_idx  = cur_idx + 1'b1;
    assign beat_done = out_valid && out_ready;

    assign dispatch_idle = (state == IDLE);
    assign out_valid     = (state == SEND);
    // data comes straight from the memory output register
    assign out_beat      = '{data: rdata, dest: acc_id, last: beats_left == '0};

    assign retire       = (state == CHECK_NEXT);
    assign retire_skip  = retire && skip_q;
    assign retire_busy  = retire && !skip_q && (code_q != SETUP_INST);
    assign retire_empty = retire && !skip_q && from_internal && !next_valid;

    always_comb begin
        port_req = '0;
        case (state)
            READ_HEADER: begin
                port_req.en   = 1'b1;
                port_req.addr = {acc_id, cur_idx};
            end
            SEND: begin
                // fetch the following word only once this one is taken
                if (out_ready) begin
                    port_req.en   = 1'b1;
                    port_req.addr = {acc_id, next_idx};
                end
            end
            RETIRE: begin
                port_req.en    = 1'b1;
                port_req.be    = VALID_BYTE_BE;
                port_req.addr  = {acc_id, first_idx};
                port_req.wdata = '0;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        host_b_req    = port_req;
        int_b_req     = port_req;
        host_b_req.en = port_req.en && !from_internal;
        int_b_req.en  = port_req.en && from_internal;
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            for (int i = 0; i < `MAX_ACCS; i++) begin
                host_idx[i] <= '0;
                int_idx[i]  <= '0;
            end
        end else begin
            case (state)
                IDLE: begin
                    if (sel_valid) begin
                        state <= READ_HEADER;
                    end
                end
                READ_HEADER: begin
                    state <= CHECK_HEADER;
                end
                CHECK_HEADER: begin
                    if (!from_internal && !hdr.valid) begin
                        state <= CHECK_NEXT;
                    end else begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    if (beat_done && out_beat.last) begin
                        state <= RETIRE;
                    end
                end
                RETIRE: begin
                    // cur_idx already points past the command
                    if (from_internal) begin
                        int_idx[acc_id] <= cur_idx;
                    end else begin
                        host_idx[acc_id] <= cur_idx;
                    end
                    state <= CHECK_NEXT;
                end
                CHECK_NEXT: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (sel_valid) begin
                    acc_id        <= sel.acc_id;
                    from_internal <= sel.from_internal;
                    first_idx     <= sel_idx;
                    cur_idx       <= sel_idx;
                end
            end
            CHECK_HEADER: begin
                code_q     <= hdr.code;
                beats_left <= cmd_length(hdr) - 1'b1;
                skip_q     <= !from_internal && !hdr.valid;
            end
            SEND: begin
                if (beat_done) begin
                    cur_idx    <= next_idx;
                    beats_left <= beats_left - 1'b1;
                end
            end
            RETIRE: begin
                // read issued with the last beat returns the next header
                next_valid <= hdr.valid;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hw/cmd_in_top.sv
// Command-input dispatcher top level. The host fills the host queue and
// accelerators fill the internal queue through port A of each memory;
// port B of both belongs to the dispatch stage. Port A read data of the
// internal queue is not brought out.
`timescale 1ns/1ns
`default_nettype none

`include "cmd_in_macros.svh"

module cmd_in_top import dispatch_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire mem_req_t             host_req,
    output logic [63:0]               host_rdata,
    input  wire mem_req_t             acc_req,
    input  wire logic                 nempty_wr,
    input  wire logic [`ACC_BITS-1:0] nempty_addr,
    input  wire logic                 avail_wr,
    input  wire logic [`ACC_BITS-1:0] avail_addr,
    output logic                      out_valid,
    output stream_beat_t              out_beat,
    input  wire logic                 out_ready
);

    mem_req_t      host_b_req;
    mem_req_t      int_b_req;
    logic [63:0]   host_b_rdata;
    logic [63:0]   int_b_rdata;
    logic          sel_valid;
    dispatch_req_t sel;
    logic          dispatch_idle;
    logic          retire;
    logic          retire_busy;
    logic          retire_empty;
    logic          retire_skip;

    cmd_queue_ram u_host_queue (
        .clk     (clk),
        .a_req   (host_req),
        .a_rdata (host_rdata),
        .b_req   (host_b_req),
        .b_rdata (host_b_rdata)
    );

    cmd_queue_ram u_int_queue (
        .clk     (clk),
        .a_req   (acc_req),
        .a_rdata (),
        .b_req   (int_b_req),
        .b_rdata (int_b_rdata)
    );

    acc_select u_acc_select (
        .clk           (clk),
        .rstn          (rstn),
        .nempty_wr     (nempty_wr),
        .nempty_addr   (nempty_addr),
        .avail_wr      (avail_wr),
        .avail_addr    (avail_addr),
        .dispatch_idle (dispatch_idle),
        .retire        (retire),
        .retire_busy   (retire_busy),
        .retire_empty  (retire_empty),
        .retire_skip   (retire_skip),
        .sel_valid     (sel_valid),
        .sel           (sel)
    );

    cmd_dispatch u_cmd_dispatch (
        .clk           (clk),
        .rstn          (rstn),
        .sel_valid     (sel_valid),
        .sel           (sel),
        .dispatch_idle (dispatch_idle),
        .host_b_req    (host_b_req),
        .int_b_req     (int_b_req),
        .host_b_rdata  (host_b_rdata),
        .int_b_rdata   (int_b_rdata),
        .out_valid     (out_valid),
        .out_beat      (out_beat),
        .out_ready     (out_ready),
        .retire        (retire),
        .retire_busy   (retire_busy),
        .retire_empty  (retire_empty),
        .retire_skip   (retire_skip)
    );

endmodule

`default_nettype wire

//--- verification/cmd_in_tb.sv
// Testbench for the command-input dispatcher top level.
// Both queue memories are preloaded right after reset with invalid headers,
// so a subqueue that never got a command reads as empty. Expected beats come
// from a shadow copy of every written word. Inputs change on falling edges.
`timescale 1ns/1ns
`default_nettype none

`include "cmd_in_macros.svh"

module cmd_in_tb import dispatch_pkg::*, cmd_format_pkg::*; ();

    localparam int TIMEOUT = 4000;
    localparam int QUIET   = 80;

    logic         clk = 1'b0;
    logic         rstn;
    mem_req_t     host_req;
    logic [63:0]  host_rdata;
    mem_req_t     acc_req;
    logic         nempty_wr;
    logic [3:0]   nempty_addr;
    logic         avail_wr;
    logic [3:0]   avail_addr;
    logic         out_valid;
    stream_beat_t out_beat;
    logic         out_ready;

    logic [31:0]  lfsr_q = 32'h809feb28;
    logic         hold_ready;
    logic [63:0]  host_mem [2**`QUEUE_ADDR_BITS];
    logic [63:0]  int_mem  [2**`QUEUE_ADDR_BITS];
    logic [5:0]   host_next [`MAX_ACCS];
    logic [5:0]   int_next  [`MAX_ACCS];
    // {last, data} per accelerator
    logic [64:0]  exp_q [`MAX_ACCS][$];
    logic [3:0]   done_log [$];
    logic         stalled;
    stream_beat_t held;
    logic [64:0]  exp_beat;
    logic [3:0]   beat_dest;

    cmd_in_top u_cmd_in_top (
        .clk         (clk),
        .rstn        (rstn),
        .host_req    (host_req),
        .host_rdata  (host_rdata),
        .acc_req     (acc_req),
        .nempty_wr   (nempty_wr),
        .nempty_addr (nempty_addr),
        .avail_wr    (avail_wr),
        .avail_addr  (avail_addr),
        .out_valid   (out_valid),
        .out_beat    (out_beat),
        .out_ready   (out_ready)
    );

    always #20 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function logic take_bit();
        take_bit = lfsr_q[31];
        lfsr_q   = lfsr_next(lfsr_q);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], take_bit()};
        end
        return r;
    endfunction

    // words in a command including the header
    function automatic int ref_cmd_len(input logic [63:0] h);
        int n;
        n = int'(h[11:8]);
        case (h[35:32])
            SETUP_INST:    return 2;
            EXEC_TASK:     return 3 + 2 * n;
            EXEC_PERIODIC: return 4 + 2 * n;
            default:       return 0;
        endcase
    endfunction

    task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("** Error [%s] expected %h actual %h", name, exp, act);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic write_word(input logic internal, input logic [9:0] addr, input logic [63:0] d);
        @(negedge clk);
        if (internal) begin
            acc_req = '{en: 1'b1, be: 8'hff, addr: addr, wdata: d};
        end else begin
            host_req = '{en: 1'b1, be: 8'hff, addr: addr, wdata: d};
        end
        @(negedge clk);
        acc_req  = '0;
        host_req = '0;
    endtask

    task automatic read_host(input logic [9:0] addr, output logic [63:0] d);
        @(negedge clk);
        host_req = '{en: 1'b1, be: 8'h00, addr: addr, wdata: 64'h0};
        @(negedge clk);
        host_req = '0;
        d = host_rdata;
    endtask

    task automatic strobe_avail(input logic [3:0] acc);
        @(negedge clk);
        avail_wr   = 1'b1;
        avail_addr = acc;
        @(negedge clk);
        avail_wr   = 1'b0;
    endtask

    task automatic strobe_nempty(input logic [3:0] acc);
        @(negedge clk);
        nempty_wr   = 1'b1;
        nempty_addr = acc;
        @(negedge clk);
        nempty_wr   = 1'b0;
    endtask

    task automatic expect_cmd(input logic internal, input logic [3:0] acc,
                              input logic [5:0] start);
        logic [63:0] w;
        logic [5:0]  idx;
        int          len;
        w   = internal ? int_mem[{acc, start}] : host_mem[{acc, start}];
        len = ref_cmd_len(w);
        for (int i = 0; i < len; i++) begin
            idx = start + 6'(i);
            w   = internal ? int_mem[{acc, idx}] : host_mem[{acc, idx}];
            exp_q[acc].push_back({i == len - 1, w});
        end
    endtask

    // body first and header last, so a poll never sees half a command
    task automatic write_cmd(input logic internal, input logic [3:0] acc, input cmd_code_e code,
                             input logic [3:0] nargs, input logic push, output logic [5:0] start);
        logic [63:0] hdr;
        logic [63:0] w;
        logic [5:0]  idx;
        int          len;
        hdr        = rand_bits(64);
        hdr[63]    = 1'b1;
        hdr[35:32] = code;
        hdr[11:8]  = nargs;
        len        = ref_cmd_len(hdr);
        start      = internal ? int_next[acc] : host_next[acc];
        for (int i = 1; i < len; i++) begin
            idx = start + 6'(i);
            w   = rand_bits(64);
            if (internal) begin
                int_mem[{acc, idx}] = w;
            end else begin
                host_mem[{acc, idx}] = w;
            end
            write_word(internal, {acc, idx}, w);
        end
        if (internal) begin
            int_mem[{acc, start}] = hdr;
            int_next[acc]         = start + 6'(len);
        end else begin
            host_mem[{acc, start}] = hdr;
            host_next[acc]         = start + 6'(len);
        end
        if (push) begin
            expect_cmd(internal, acc, start);
        end
        write_word(internal, {acc, start}, hdr);
    endtask

    task automatic wait_drained(input logic [3:0] acc);
        int n;
        n = 0;
        while (exp_q[acc].size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q[acc].size() != 0) begin
            fail_plain($sformatf("timeout: command for accelerator %0d never completed", acc));
        end
    endtask

    task automatic wait_stream_for(input logic [3:0] acc);
        int n;
        n = 0;
        while (!(out_valid && out_beat.dest == acc) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!(out_valid && out_beat.dest == acc)) begin
            fail_plain($sformatf("timeout: no stream started for accelerator %0d", acc));
        end
    endtask

    // polls until the retire write lands, then checks the whole word
    task automatic check_header_cleared(input logic [3:0] acc, input logic [5:0] start);
        logic [63:0] exp;
        logic [63:0] d;
        int          n;
        exp = host_mem[{acc, start}] & 64'h00ff_ffff_ffff_ffff;
        n   = 0;
        d   = '1;
        while (d[63:56] != 8'h00 && n < TIMEOUT) begin
            read_host({acc, start}, d);
            n++;
        end
        assert (d[63:56] == 8'h00) else fail_plain("timeout: header valid byte never cleared");
        assert (d == exp) else fail_value("header clear", exp, d);
        host_mem[{acc, start}] = exp;
    endtask

    task automatic run_host_cmd(input logic [3:0] acc, input cmd_code_e code,
                                input logic [3:0] nargs);
        logic [5:0] start;
        write_cmd(1'b0, acc, code, nargs, 1'b1, start);
        wait_drained(acc);
        check_header_cleared(acc, start);
        if (code != SETUP_INST) begin
            strobe_avail(acc);
        end
    endtask

    // checks every transferred beat and holds stalled beats to their value
    always @(posedge clk) begin
        if (rstn) begin
            if (stalled) begin
                assert (out_valid) else fail_plain("out_valid dropped while stalled");
                assert (out_beat == held) else fail_value("stall hold", held.data, out_beat.data);
            end
            if (out_valid && out_ready) begin
                beat_dest = out_beat.dest;
                assert (exp_q[beat_dest].size() != 0)
                else fail_plain($sformatf("unexpected beat for accelerator %0d", beat_dest));
                exp_beat = exp_q[beat_dest].pop_front();
                assert (out_beat.data == exp_beat[63:0])
                else fail_value("beat data", exp_beat[63:0], out_beat.data);
                assert (out_beat.last == exp_beat[64])
                else fail_value("beat last", 64'(exp_beat[64]), 64'(out_beat.last));
                if (out_beat.last) begin
                    done_log.push_back(beat_dest);
                end
                stalled = 1'b0;
            end else if (out_valid) begin
                stalled = 1'b1;
                held    = out_beat;
            end else begin
                stalled = 1'b0;
            end
        end else begin
            stalled = 1'b0;
        end
    end

    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            out_ready = hold_ready ? 1'b0 : take_bit();
        end
    end

    initial begin
        logic [5:0] s;
        logic [9:0] a;
        rstn        = 1'b0;
        host_req    = '0;
        acc_req     = '0;
        nempty_wr   = 1'b0;
        nempty_addr = '0;
        avail_wr    = 1'b0;
        avail_addr  = '0;
        hold_ready  = 1'b0;
        stalled     = 1'b0;
        for (int i = 0; i < `MAX_ACCS; i++) begin
            host_next[i] = '0;
            int_next[i]  = '0;
        end
        repeat (5) @(negedge clk);
        rstn = 1'b1;

        // preload with every valid byte clear
        // index 0 of each subqueue goes first so polling never reads an unwritten header
        for (int i = 0; i < 2**`QUEUE_ADDR_BITS; i++) begin
            a           = {i[3:0], i[9:4]};
            host_mem[a] = {8'h00, 8'ha5, 38'h0, a};
            int_mem[a]  = {8'h00, 8'h5a, 38'h0, a};
            @(negedge clk);
            host_req = '{en: 1'b1, be: 8'hff, addr: a, wdata: host_mem[a]};
            acc_req  = '{en: 1'b1, be: 8'hff, addr: a, wdata: int_mem[a]};
        end
        @(negedge clk);
        host_req = '0;
        acc_req  = '0;

        // all three command types over several rounds of subqueues
        for (int r = 0; r < 3; r++) begin
            run_host_cmd(4'(r), EXEC_TASK, 4'(rand_bits(3)));
            run_host_cmd(4'(r + 1), SETUP_INST, 4'(rand_bits(3)));
            run_host_cmd(4'(r + 2), EXEC_PERIODIC, 4'(rand_bits(3)));
        end

        // busy accelerator holds its second command until avail_wr
        begin
            logic [5:0] sa;
            logic [5:0] sb;
            write_cmd(1'b0, 4'd3, EXEC_TASK, 4'd2, 1'b1, sa);
            write_cmd(1'b0, 4'd3, EXEC_PERIODIC, 4'd1, 1'b0, sb);
            wait_drained(4'd3);
            check_header_cleared(4'd3, sa);
            repeat (QUIET) @(negedge clk);
            expect_cmd(1'b0, 4'd3, sb);
            strobe_avail(4'd3);
            wait_drained(4'd3);
            check_header_cleared(4'd3, sb);
            strobe_avail(4'd3);
        end

        // back-to-back setup commands are not blocked
        write_cmd(1'b0, 4'd8, SETUP_INST, 4'd0, 1'b1, s);
        write_cmd(1'b0, 4'd8, SETUP_INST, 4'd3, 1'b1, s);
        wait_drained(4'd8);
        check_header_cleared(4'd8, s);

        // internal command goes ahead of pending host commands
        begin
            logic [5:0] s2;
            logic [5:0] s6;
            logic [5:0] s7;
            hold_ready = 1'b1;
            write_cmd(1'b0, 4'd2, EXEC_PERIODIC, 4'd7, 1'b1, s2);
            wait_stream_for(4'd2);
            write_cmd(1'b0, 4'd6, EXEC_TASK, 4'd1, 1'b1, s6);
            write_cmd(1'b0, 4'd7, EXEC_TASK, 4'd0, 1'b1, s7);
            write_cmd(1'b1, 4'd5, EXEC_TASK, 4'd3, 1'b1, s);
            strobe_nempty(4'd5);
            done_log.delete();
            hold_ready = 1'b0;
            wait_drained(4'd2);
            wait_drained(4'd5);
            wait_drained(4'd6);
            wait_drained(4'd7);
            assert (done_log.size() >= 2) else fail_plain("completion log too short");
            assert (done_log[0] == 4'd2)
            else fail_value("order first", 64'd2, 64'(done_log[0]));
            assert (done_log[1] == 4'd5)
            else fail_value("order internal", 64'd5, 64'(done_log[1]));
            check_header_cleared(4'd2, s2);
            check_header_cleared(4'd6, s6);
            check_header_cleared(4'd7, s7);
            strobe_avail(4'd2);
            strobe_avail(4'd6);
            strobe_avail(4'd7);
            strobe_avail(4'd5);
        end

        // internal subqueue is empty now and waits for nempty_wr
        repeat (QUIET) @(negedge clk);
        write_cmd(1'b1, 4'd5, SETUP_INST, 4'd0, 1'b1, s);
        repeat (QUIET) @(negedge clk);
        assert (exp_q[5].size() == 2) else fail_plain("internal dispatch without nempty_wr");
        strobe_nempty(4'd5);
        wait_drained(4'd5);

        // subqueue 12 was polled while never written and still starts at index 0
        run_host_cmd(4'd12, EXEC_TASK, 4'd4);

        repeat (QUIET) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+common
common/cmd_format_pkg.sv
common/dispatch_pkg.sv
hw/cmd_queue_ram.sv
hw/acc_select.sv
cmd_dispatch/cmd_dispatch.sv
hw/cmd_in_top.sv
verification/cmd_in_tb.sv

//--- Makefile
# Verilator build and run of the command-input dispatcher testbench.
# The run fails with a non-zero exit status when the testbench fails.

VERILATOR ?= verilator
TOP       ?= cmd_in_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
EXTRA     ?=

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS EXTRA"

$(BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
